// ==== src/bus_pkg.sv ====
// ==================================================================
// register bus definitions
// address and data widths, I/O page map, block region enum
// ==================================================================

`default_nettype none

package bus_pkg;

	// ==================================================================
	// bus widths
	// ==================================================================
	localparam int ADR_W = 32;
	localparam int DAT_W = 32;

	// ==================================================================
	// I/O page map
	// ==================================================================
	// address bits 31..24 pick the I/O page
	localparam int IO_PAGE_LSB = 24;
	localparam int IO_PAGE_W = 8;
	localparam logic [IO_PAGE_W-1:0] IO_PAGE = 8'hFE;

	// address bits 11..8 pick the block inside the page
	localparam int REGION_LSB = 8;
	localparam int REGION_W = 4;

	// decoded target of one access
	// everything that is not timer or pic ends up as none
	typedef enum logic [1:0]
	{
		REGION_TIMER = 2'd0,
		REGION_PIC = 2'd1,
		REGION_NONE = 2'd2
	} region_e;

endpackage

`default_nettype wire

// ==== src/irq_pkg.sv ====
// ==================================================================
// timer and interrupt controller definitions
// channel and source counts, control bit positions
// register select enums and the timer mode enum
// ==================================================================

`default_nettype none

package irq_pkg;

	// timer channels and the width of the channel select
	localparam int TMR_CH = 4;
	localparam int CH_W = 2;

	// interrupt lines and the width of a line index
	localparam int IRQ_SRC = 32;
	localparam int SRC_IDX_W = 5;
	localparam int CAUSE_W = 8;

	// channel n drives line TMR_IRQ_BASE+n
	localparam int TMR_IRQ_BASE = 28;

	// bit positions in the timer CTRL and STATUS words
	localparam int CTRL_EN_BIT = 0;
	localparam int CTRL_MODE_BIT = 1;
	localparam int STAT_EXP_BIT = 0;
	localparam int STAT_OUT_BIT = 1;

	// timer register select from address bits 3..2
	typedef enum logic [1:0]
	{
		TMR_RELOAD = 2'd0,
		TMR_COUNT = 2'd1,
		TMR_CTRL = 2'd2,
		TMR_STATUS = 2'd3
	} tmr_reg_e;

	typedef enum logic {MODE_ONESHOT = 1'b0, MODE_PERIODIC = 1'b1} tmr_mode_e;

	// controller register select from address bits 3..2
	typedef enum logic [1:0]
	{
		PIC_MASK = 2'd0,
		PIC_BASE = 2'd1,
		PIC_PENDING = 2'd2,
		PIC_CAUSE = 2'd3
	} pic_reg_e;

endpackage

`default_nettype wire

// ==== src/interval_timer.sv ====
// ==================================================================
// interval timer with four down-counting channels
// external channel clock and gate per channel, expiry status,
// toggling output pins and one interrupt level per channel
// ==================================================================

`default_nettype none
`timescale 1ns/10ps

module interval_timer (
	input wire clk_i,
	input wire rst_n_i,
	input wire req_i,
	input wire we_i,
	input wire [5:0] adr_i,
	input wire [bus_pkg::DAT_W-1:0] wdat_i,
	output logic ack_o,
	output logic [bus_pkg::DAT_W-1:0] rdat_o,
	input wire [irq_pkg::TMR_CH-1:0] chan_clk_i,
	input wire [irq_pkg::TMR_CH-1:0] chan_gate_i,
	output logic [irq_pkg::TMR_CH-1:0] out_o,
	output logic [irq_pkg::TMR_CH-1:0] irq_o
);
	import bus_pkg::*;
	import irq_pkg::*;

	// per channel registers
	logic [DAT_W-1:0] reload [TMR_CH];
	logic [DAT_W-1:0] count [TMR_CH];
	tmr_mode_e ctrl_mode [TMR_CH];
	logic [TMR_CH-1:0] ctrl_en;
	logic [TMR_CH-1:0] status;

	// synchronizer stages, s3 holds the previous clock level
	logic [TMR_CH-1:0] clk_s1;
	logic [TMR_CH-1:0] clk_s2;
	logic [TMR_CH-1:0] clk_s3;
	logic [TMR_CH-1:0] gate_s1;
	logic [TMR_CH-1:0] gate_s2;
	logic [TMR_CH-1:0] run;

	// access decode
	logic [CH_W-1:0] ch_sel;
	tmr_reg_e reg_sel;
	logic [TMR_CH-1:0] wr_ch;
	logic [DAT_W-1:0] rd_word;

	assign ch_sel = adr_i[5:4];
	assign reg_sel = tmr_reg_e'(adr_i[3:2]);

	always_comb
	begin
		for (int n = 0; n < TMR_CH; n++)
			wr_ch[n] = req_i && we_i && (ch_sel == CH_W'(n));
	end

	// ==================================================================
	// channel clock and gate synchronizers
	// ==================================================================
	always_ff @(posedge clk_i)
	begin
		if (!rst_n_i)
		begin
			clk_s1 <= '0;
			clk_s2 <= '0;
			clk_s3 <= '0;
			gate_s1 <= '0;
			gate_s2 <= '0;
		end
		else
		begin
			clk_s1 <= chan_clk_i;
			clk_s2 <= clk_s1;
			clk_s3 <= clk_s2;
			gate_s1 <= chan_gate_i;
			gate_s2 <= gate_s1;
		end
	end

	// rising edge of the channel clock, qualified by enable and gate
	assign run = clk_s2 & ~clk_s3 & gate_s2 & ctrl_en;

	// ==================================================================
	// counters and control registers
	// ==================================================================
	always_ff @(posedge clk_i)
	begin
		if (!rst_n_i)
		begin
			for (int n = 0; n < TMR_CH; n++)
			begin
				reload[n] <= '0;
				count[n] <= '0;
				ctrl_mode[n] <= MODE_ONESHOT;
			end
			ctrl_en <= '0;
			status <= '0;
			out_o <= '0;
		end
		else
		begin
			for (int n = 0; n < TMR_CH; n++)
			begin
				// write-one-to-clear, an expiry in the same cycle still sets
				if (wr_ch[n] && reg_sel == TMR_STATUS && wdat_i[STAT_EXP_BIT])
					status[n] <= 1'b0;
				if (run[n] && count[n] != '0)
				begin
					count[n] <= count[n] - 1'b1;
					// 1 to 0 is the expiry
					if (count[n] == DAT_W'(1))
					begin
						status[n] <= 1'b1;
						out_o[n] <= ~out_o[n];
						if (ctrl_mode[n] == MODE_PERIODIC)
							count[n] <= reload[n];
						else
							ctrl_en[n] <= 1'b0;
					end
				end
				// software writes override the tick
				if (wr_ch[n] && reg_sel == TMR_RELOAD)
				begin
					reload[n] <= wdat_i;
					count[n] <= wdat_i;
				end
				if (wr_ch[n] && reg_sel == TMR_CTRL)
				begin
					ctrl_en[n] <= wdat_i[CTRL_EN_BIT];
					ctrl_mode[n] <= tmr_mode_e'(wdat_i[CTRL_MODE_BIT]);
				end
			end
		end
	end

	assign irq_o = status;

	// ==================================================================
	// read path and acknowledge
	// ==================================================================
	always_comb
	begin
		rd_word = '0;
		case (reg_sel)
			TMR_RELOAD: rd_word = reload[ch_sel];
			TMR_COUNT: rd_word = count[ch_sel];
			TMR_CTRL:
			begin
				rd_word[CTRL_EN_BIT] = ctrl_en[ch_sel];
				rd_word[CTRL_MODE_BIT] = ctrl_mode[ch_sel];
			end
			TMR_STATUS:
			begin
				rd_word[STAT_EXP_BIT] = status[ch_sel];
				rd_word[STAT_OUT_BIT] = out_o[ch_sel];
			end
		endcase
	end

	always_ff @(posedge clk_i)
	begin
		if (!rst_n_i)
			ack_o <= 1'b0;
		else
			ack_o <= req_i;
	end

	// read data has no reset, it is only sampled with ack_o
	always_ff @(posedge clk_i)
	begin
		if (req_i && !we_i)
			rdat_o <= rd_word;
	end

	// count only ever comes from reload or counts down from it
	for (genvar g = 0; g < TMR_CH; g++)
	begin : g_chk
		a_count_le_reload: assert property (@(posedge clk_i) disable iff (!rst_n_i)
			(ctrl_en[g] && reload[g] != '0) |-> (count[g] <= reload[g]));
	end

endmodule

`default_nettype wire

// ==== src/irq_controller.sv ====
// ==================================================================
// interrupt controller for 32 level-sensitive lines
// mask and vector base registers, pending capture,
// highest-line priority encoder and cause generation
// ==================================================================

`default_nettype none
`timescale 1ns/10ps

module irq_controller (
	input wire clk_i,
	input wire rst_n_i,
	input wire req_i,
	input wire we_i,
	input wire [1:0] adr_i,
	input wire [bus_pkg::DAT_W-1:0] wdat_i,
	input wire [irq_pkg::IRQ_SRC-1:0] src_i,
	output logic ack_o,
	output logic [bus_pkg::DAT_W-1:0] rdat_o,
	output logic irq_o,
	output logic [irq_pkg::CAUSE_W-1:0] cause_o
);
	import bus_pkg::*;
	import irq_pkg::*;

	logic [IRQ_SRC-1:0] mask;
	logic [CAUSE_W-1:0] base;
	logic [IRQ_SRC-1:0] pending;

	// next pending vector and its highest set line
	logic [IRQ_SRC-1:0] pend_next;
	logic [SRC_IDX_W-1:0] top_idx;
	logic any_pend;

	pic_reg_e reg_sel;
	logic [DAT_W-1:0] rd_word;

	assign reg_sel = pic_reg_e'(adr_i);

	// ==================================================================
	// pending and priority
	// ==================================================================
	// line 0 is reserved and masked off here
	assign pend_next = src_i & mask & ~IRQ_SRC'(1);
	assign any_pend = |pend_next;

	// scan upward so the highest line is the one that sticks
	always_comb
	begin
		top_idx = '0;
		for (int i = 1; i < IRQ_SRC; i++)
			if (pend_next[i])
				top_idx = SRC_IDX_W'(i);
	end

	always_ff @(posedge clk_i)
	begin
		if (!rst_n_i)
		begin
			mask <= '0;
			base <= '0;
			pending <= '0;
			irq_o <= 1'b0;
			cause_o <= '0;
			ack_o <= 1'b0;
		end
		else
		begin
			ack_o <= req_i;
			if (req_i && we_i)
			begin
				case (reg_sel)
					PIC_MASK: mask <= wdat_i[IRQ_SRC-1:0];
					PIC_BASE: base <= wdat_i[CAUSE_W-1:0];
					// pending and cause are read-only
					default: ;
				endcase
			end
			pending <= pend_next;
			irq_o <= any_pend;
			// cause wraps within 8 bits
			cause_o <= any_pend ? base + CAUSE_W'(top_idx) : '0;
		end
	end

	// ==================================================================
	// register read
	// ==================================================================
	always_comb
	begin
		rd_word = '0;
		case (reg_sel)
			PIC_MASK: rd_word = DAT_W'(mask);
			PIC_BASE: rd_word = DAT_W'(base);
			PIC_PENDING: rd_word = DAT_W'(pending);
			PIC_CAUSE: rd_word = DAT_W'(cause_o);
		endcase
	end

	always_ff @(posedge clk_i)
	begin
		if (req_i && !we_i)
			rdat_o <= rd_word;
	end

	// the request line to the cpu follows the pending register
	a_irq_has_pending: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		irq_o |-> (pending != '0));

endmodule

`default_nettype wire

// ==== src/periph_bus_router.sv ====
// ==================================================================
// register bus router for the I/O page
// region decode, request steering, read data merge and
// the error acknowledge for unmapped addresses
// ==================================================================

`default_nettype none
`timescale 1ns/10ps

module periph_bus_router (
	input wire clk_i,
	input wire rst_n_i,
	input wire req_i,
	input wire [bus_pkg::ADR_W-1:0] adr_i,
	input wire tmr_ack_i,
	input wire [bus_pkg::DAT_W-1:0] tmr_rdat_i,
	input wire pic_ack_i,
	input wire [bus_pkg::DAT_W-1:0] pic_rdat_i,
	output logic tmr_req_o,
	output logic pic_req_o,
	output logic ack_o,
	output logic err_o,
	output logic [bus_pkg::DAT_W-1:0] rdat_o
);
	import bus_pkg::*;

	region_e region;
	logic page_hit;
	logic [REGION_W-1:0] blk;
	logic err_q;

	// ==================================================================
	// address decode
	// ==================================================================
	assign page_hit = (adr_i[IO_PAGE_LSB +: IO_PAGE_W] == IO_PAGE);
	assign blk = adr_i[REGION_LSB +: REGION_W];

	always_comb
	begin
		region = REGION_NONE;
		if (page_hit && blk == REGION_W'(REGION_TIMER))
			region = REGION_TIMER;
		else if (page_hit && blk == REGION_W'(REGION_PIC))
			region = REGION_PIC;
	end

	// strobe goes to exactly one block
	assign tmr_req_o = req_i && (region == REGION_TIMER);
	assign pic_req_o = req_i && (region == REGION_PIC);

	// unmapped access answers itself one cycle later
	always_ff @(posedge clk_i)
	begin
		if (!rst_n_i)
			err_q <= 1'b0;
		else
			err_q <= req_i && (region == REGION_NONE);
	end

	// response merge
	assign ack_o = tmr_ack_i | pic_ack_i | err_q;
	assign err_o = err_q;
	assign rdat_o = ({DAT_W{tmr_ack_i}} & tmr_rdat_i) | ({DAT_W{pic_ack_i}} & pic_rdat_i);

	a_ack_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(tmr_ack_i && pic_ack_i));

	// every request is answered on the next clock
	a_ack_next: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		req_i |=> ack_o);

endmodule

`default_nettype wire

// ==== src/mpu_periph.sv ====
// ==================================================================
// peripheral top level
// bus router, interval timer and interrupt controller,
// with the timer interrupts merged onto the upper irq lines
// ==================================================================

`default_nettype none
`timescale 1ns/10ps

module mpu_periph (
	input wire clk_i,
	input wire rst_n_i,
	input wire req_i,
	input wire we_i,
	input wire [bus_pkg::ADR_W-1:0] adr_i,
	input wire [bus_pkg::DAT_W-1:0] wdat_i,
	output logic [bus_pkg::DAT_W-1:0] rdat_o,
	output logic ack_o,
	output logic err_o,
	input wire [irq_pkg::IRQ_SRC-1:0] irq_bus_i,
	input wire [irq_pkg::TMR_CH-1:0] chan_clk_i,
	input wire [irq_pkg::TMR_CH-1:0] chan_gate_i,
	output logic [irq_pkg::TMR_CH-1:0] tmr_out_o,
	output logic irq_o,
	output logic [irq_pkg::CAUSE_W-1:0] cause_o
);
	import bus_pkg::*;
	import irq_pkg::*;

	logic tmr_req;
	logic pic_req;
	logic tmr_ack;
	logic pic_ack;
	logic [DAT_W-1:0] tmr_rdat;
	logic [DAT_W-1:0] pic_rdat;
	logic [TMR_CH-1:0] tmr_irq;
	logic [IRQ_SRC-1:0] irq_src;

	// timer channels land on lines 28..31
	assign irq_src = irq_bus_i | ({{(IRQ_SRC-TMR_CH){1'b0}}, tmr_irq} << TMR_IRQ_BASE);

	periph_bus_router u_router (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.req_i(req_i),
		.adr_i(adr_i),
		.tmr_ack_i(tmr_ack),
		.tmr_rdat_i(tmr_rdat),
		.pic_ack_i(pic_ack),
		.pic_rdat_i(pic_rdat),
		.tmr_req_o(tmr_req),
		.pic_req_o(pic_req),
		.ack_o(ack_o),
		.err_o(err_o),
		.rdat_o(rdat_o)
	);

	interval_timer u_timer (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.req_i(tmr_req),
		.we_i(we_i),
		.adr_i(adr_i[5:0]),
		.wdat_i(wdat_i),
		.ack_o(tmr_ack),
		.rdat_o(tmr_rdat),
		.chan_clk_i(chan_clk_i),
		.chan_gate_i(chan_gate_i),
		.out_o(tmr_out_o),
		.irq_o(tmr_irq)
	);

	// register select only needs address bits 3..2
	irq_controller u_pic (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.req_i(pic_req),
		.we_i(we_i),
		.adr_i(adr_i[3:2]),
		.wdat_i(wdat_i),
		.src_i(irq_src),
		.ack_o(pic_ack),
		.rdat_o(pic_rdat),
		.irq_o(irq_o),
		.cause_o(cause_o)
	);

endmodule

`default_nettype wire

// ==== bench/tb_clock_gen.sv ====
// ==================================================================
// testbench clock and reset source
// 8 ns clock, active-low reset held for two cycles
// ==================================================================

`default_nettype none
`timescale 1ns/10ps

module tb_clock_gen (
	output logic clk_o,
	output logic rst_n_o
);

	initial
	begin
		clk_o = 1'b0;
		forever #4 clk_o = ~clk_o;
	end

	// release on the second rising edge
	initial
	begin
		rst_n_o = 1'b0;
		repeat (2) @(posedge clk_o);
		rst_n_o <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== bench/tb_mpu_periph.sv ====
// ==================================================================
// testbench for the peripheral top level
// table of bus, channel clock and interrupt steps applied in a loop
// LFSR data, per-step report, cycle timeout and final counts
// ==================================================================

`default_nettype none
`timescale 1ns/10ps

module tb_mpu_periph;
	import bus_pkg::*;
	import irq_pkg::*;

	typedef enum int {ACT_WR, ACT_RD, ACT_PULSE, ACT_GATE, ACT_IRQBUS, ACT_WAITIRQ} act_e;

	// one table step where exp only counts when chk is set
	typedef struct {
		string name;
		act_e act;
		logic [31:0] adr;
		logic [31:0] dat;
		logic [31:0] exp;
		bit chk;
	} entry_t;

	entry_t tbl[$];

	logic clk;
	logic rst_n;
	logic req;
	logic we;
	logic [31:0] adr;
	logic [31:0] wdat;
	logic [31:0] rdat;
	logic ack;
	logic err;
	logic [31:0] irq_bus;
	logic [3:0] chan_clk;
	logic [3:0] chan_gate;
	logic [3:0] tmr_out;
	logic irq;
	logic [7:0] cause;

	logic [15:0] lfsr;
	int cycles;
	int limit;
	int n_pass;
	int n_fail;

	tb_clock_gen u_clk (.clk_o(clk), .rst_n_o(rst_n));

	mpu_periph UUT (
		.clk_i(clk),
		.rst_n_i(rst_n),
		.req_i(req),
		.we_i(we),
		.adr_i(adr),
		.wdat_i(wdat),
		.rdat_o(rdat),
		.ack_o(ack),
		.err_o(err),
		.irq_bus_i(irq_bus),
		.chan_clk_i(chan_clk),
		.chan_gate_i(chan_gate),
		.tmr_out_o(tmr_out),
		.irq_o(irq),
		.cause_o(cause)
	);

	// ==================================================================
	// helpers
	// ==================================================================
	// fibonacci lfsr with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// one step for every bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// page FE block 0 with the channel in bits 5..4
	function automatic logic [31:0] tmr_adr(input int ch, input tmr_reg_e r);
		return {8'hFE, 16'h0000, 2'b00, 2'(ch), r, 2'b00};
	endfunction

	// page FE, block 1
	function automatic logic [31:0] pic_adr(input pic_reg_e r);
		return {8'hFE, 12'h000, 4'h1, 4'h0, r, 2'b00};
	endfunction

	// outside the page, or block 2 and up, has no target
	function automatic bit expect_err(input logic [31:0] a);
		return (a[31:24] != 8'hFE) || (a[11:8] > 4'd1);
	endfunction

	// timer STATUS register of any channel
	function automatic bit is_tmr_status(input logic [31:0] a);
		return (a[31:24] == 8'hFE) && (a[11:8] == 4'd0) && (a[3:2] == TMR_STATUS);
	endfunction

	// highest set line above line 0
	function automatic logic [7:0] top_line(input logic [31:0] v);
		for (int i = 31; i > 0; i--)
			if (v[i])
				return 8'(i);
		return 8'd0;
	endfunction

	task automatic add_entry(input string name, input act_e act, input logic [31:0] a,
		input logic [31:0] d, input logic [31:0] x, input bit chk);
		entry_t e;
		e.name = name;
		e.act = act;
		e.adr = a;
		e.dat = d;
		e.exp = x;
		e.chk = chk;
		tbl.push_back(e);
	endtask

	// ==================================================================
	// stimulus table
	// ==================================================================
	task automatic build_table();
		logic [31:0] r;
		logic [31:0] m;
		logic [31:0] p;
		logic [7:0] b;
		int rl;
		int k;
		// reset values
		add_entry("rst_ctrl", ACT_RD, tmr_adr(0, TMR_CTRL), 0, 0, 1);
		add_entry("rst_count", ACT_RD, tmr_adr(0, TMR_COUNT), 0, 0, 1);
		add_entry("rst_mask", ACT_RD, pic_adr(PIC_MASK), 0, 0, 1);
		// register access
		for (int n = 0; n < 4; n++)
		begin
			r = rand_bits(32);
			add_entry($sformatf("reload_wr%0d", n), ACT_WR, tmr_adr(n, TMR_RELOAD), r, 0, 0);
			add_entry($sformatf("reload_rd%0d", n), ACT_RD, tmr_adr(n, TMR_RELOAD), 0, r, 1);
			add_entry($sformatf("count_rd%0d", n), ACT_RD, tmr_adr(n, TMR_COUNT), 0, r, 1);
		end
		m = rand_bits(32);
		b = 8'(rand_bits(8));
		add_entry("mask_wr", ACT_WR, pic_adr(PIC_MASK), m, 0, 0);
		add_entry("mask_rd", ACT_RD, pic_adr(PIC_MASK), 0, m, 1);
		add_entry("base_wr", ACT_WR, pic_adr(PIC_BASE), 32'(b), 0, 0);
		add_entry("base_rd", ACT_RD, pic_adr(PIC_BASE), 0, 32'(b), 1);
		add_entry("err_page", ACT_RD, 32'h1200_0100, 0, 0, 0);
		add_entry("err_block2", ACT_RD, 32'hFE00_0200, 0, 0, 0);
		add_entry("err_block_f", ACT_WR, 32'hFE00_0F04, 32'h5A, 0, 0);
		// one-shot on each channel with all gates open
		add_entry("gates_on", ACT_GATE, 0, 32'hF, 0, 0);
		for (int n = 0; n < 4; n++)
		begin
			add_entry($sformatf("os_mask%0d", n), ACT_WR, pic_adr(PIC_MASK), 32'd1 << (28 + n), 0, 0);
			add_entry($sformatf("os_reload%0d", n), ACT_WR, tmr_adr(n, TMR_RELOAD), 3, 0, 0);
			add_entry($sformatf("os_ctrl%0d", n), ACT_WR, tmr_adr(n, TMR_CTRL), 1, 0, 0);
			add_entry($sformatf("os_pulse%0d", n), ACT_PULSE, n, 3, 0, 0);
			add_entry($sformatf("os_irq%0d", n), ACT_WAITIRQ, 0, 1, 32'(8'(b + 8'(28 + n))), 1);
			add_entry($sformatf("os_status%0d", n), ACT_RD, tmr_adr(n, TMR_STATUS), 0, 3, 1);
			add_entry($sformatf("os_en_off%0d", n), ACT_RD, tmr_adr(n, TMR_CTRL), 0, 0, 1);
			add_entry($sformatf("os_clear%0d", n), ACT_WR, tmr_adr(n, TMR_STATUS), 1, 0, 0);
			add_entry($sformatf("os_irq_off%0d", n), ACT_WAITIRQ, 0, 0, 0, 1);
		end
		// periodic on channel 1 whose output starts high
		rl = 3 + int'(rand_bits(2));
		k = 2 * rl + 1 + int'(rand_bits(1));
		add_entry("per_reload", ACT_WR, tmr_adr(1, TMR_RELOAD), rl, 0, 0);
		add_entry("per_ctrl", ACT_WR, tmr_adr(1, TMR_CTRL), 3, 0, 0);
		add_entry("per_pulse_r", ACT_PULSE, 1, rl, 0, 0);
		add_entry("per_status_r", ACT_RD, tmr_adr(1, TMR_STATUS), 0, 1, 1);
		add_entry("per_count_r", ACT_RD, tmr_adr(1, TMR_COUNT), 0, rl, 1);
		add_entry("per_pulse_k", ACT_PULSE, 1, k - rl, 0, 0);
		add_entry("per_count_k", ACT_RD, tmr_adr(1, TMR_COUNT), 0, rl - (k % rl), 1);
		add_entry("per_status_k", ACT_RD, tmr_adr(1, TMR_STATUS), 0,
			{30'd0, ~1'((k / rl) & 1), 1'b1}, 1);
		add_entry("gate1_off", ACT_GATE, 0, 32'hD, 0, 0);
		add_entry("gated_pulse", ACT_PULSE, 1, 2, 0, 0);
		add_entry("gated_count", ACT_RD, tmr_adr(1, TMR_COUNT), 0, rl - (k % rl), 1);
		add_entry("gate1_on", ACT_GATE, 0, 32'hF, 0, 0);
		add_entry("per_stop", ACT_WR, tmr_adr(1, TMR_CTRL), 0, 0, 0);
		add_entry("per_clear", ACT_WR, tmr_adr(1, TMR_STATUS), 1, 0, 0);
		// priority and masking
		m = rand_bits(32);
		p = rand_bits(32) | 32'd1;
		add_entry("pri_mask", ACT_WR, pic_adr(PIC_MASK), m, 0, 0);
		add_entry("pri_bus", ACT_IRQBUS, 0, p, 0, 0);
		add_entry("pri_pending", ACT_RD, pic_adr(PIC_PENDING), 0, p & m & ~32'd1, 1);
		add_entry("pri_cause", ACT_WAITIRQ, 0, 32'((p & m & ~32'd1) != 0),
			((p & m & ~32'd1) != 0) ? 32'(8'(b + top_line(p & m))) : 0, 1);
		add_entry("pri_clear", ACT_IRQBUS, 0, 0, 0, 0);
		add_entry("pri_drop", ACT_WAITIRQ, 0, 0, 0, 1);
		add_entry("masked_bus", ACT_IRQBUS, 0, ~m | 32'd1, 0, 0);
		add_entry("masked_quiet", ACT_WAITIRQ, 0, 0, 0, 1);
		add_entry("mask_all", ACT_WR, pic_adr(PIC_MASK), 32'hFFFF_FFFF, 0, 0);
		add_entry("line0_bus", ACT_IRQBUS, 0, 1, 0, 0);
		add_entry("line0_quiet", ACT_WAITIRQ, 0, 0, 0, 1);
		add_entry("bus_idle", ACT_IRQBUS, 0, 0, 0, 0);
	endtask

	// ==================================================================
	// drivers
	// ==================================================================
	task automatic bus_access(input bit wr, input logic [31:0] a, input logic [31:0] d,
		output logic [31:0] rd, output bit got_ack, output bit got_err);
		int w;
		rd = '0;
		got_ack = 1'b0;
		got_err = 1'b0;
		w = 0;
		@(posedge clk);
		req <= 1'b1;
		we <= wr;
		adr <= a;
		wdat <= d;
		@(posedge clk);
		req <= 1'b0;
		we <= 1'b0;
		// sample on the falling edge away from the update
		while (!got_ack && w < 16)
		begin
			@(negedge clk);
			if (ack)
			begin
				got_ack = 1'b1;
				got_err = err;
				rd = rdat;
			end
			w++;
		end
	endtask

	// each pulse is 3 cycles high and 4 low so the synchronizer sees it
	task automatic pulse_clock(input int ch, input int times);
		repeat (times)
		begin
			@(posedge clk);
			chan_clk[ch] <= 1'b1;
			repeat (3) @(posedge clk);
			chan_clk[ch] <= 1'b0;
			repeat (3) @(posedge clk);
		end
	endtask

	task automatic wait_irq(input logic level, output bit seen);
		int w;
		seen = 1'b0;
		w = 0;
		while (!seen && w < 32)
		begin
			@(negedge clk);
			seen = (irq === level);
			w++;
		end
	endtask

	task automatic run_entry(input entry_t e);
		logic [31:0] rd;
		bit got_ack;
		bit got_err;
		bit bad;
		bad = 1'b0;
		case (e.act)
			ACT_WR, ACT_RD:
			begin
				bus_access(e.act == ACT_WR, e.adr, e.dat, rd, got_ack, got_err);
				if (!got_ack)
				begin
					$display("%s: the bus access was never acknowledged", e.name);
					bad = 1'b1;
				end
				else if (got_err != expect_err(e.adr))
				begin
					$display("error %s expected err %0d actual %0d", e.name,
						expect_err(e.adr), got_err);
					bad = 1'b1;
				end
				else if (e.chk && rd !== e.exp)
				begin
					$display("error %s expected %h actual %h", e.name, e.exp, rd);
					bad = 1'b1;
				end
				else if (e.chk && is_tmr_status(e.adr)
					&& tmr_out[e.adr[5:4]] !== e.exp[STAT_OUT_BIT])
				begin
					// output pin of the channel follows its toggle count
					$display("error %s expected tmr_out %b actual %b", e.name,
						e.exp[STAT_OUT_BIT], tmr_out[e.adr[5:4]]);
					bad = 1'b1;
				end
			end
			ACT_PULSE:
				pulse_clock(int'(e.adr), int'(e.dat));
			ACT_GATE:
			begin
				@(posedge clk);
				chan_gate <= e.dat[3:0];
				repeat (4) @(posedge clk);
			end
			ACT_IRQBUS:
			begin
				// settle time covers the controller register stage
				@(posedge clk);
				irq_bus <= e.dat;
				repeat (4) @(posedge clk);
			end
			ACT_WAITIRQ:
			begin
				wait_irq(e.dat[0], got_ack);
				if (!got_ack)
				begin
					$display("%s: irq_o never went to %0d", e.name, e.dat[0]);
					bad = 1'b1;
				end
				else if (e.chk && cause !== e.exp[7:0])
				begin
					$display("error %s expected %h actual %h", e.name, e.exp[7:0], cause);
					bad = 1'b1;
				end
			end
		endcase
		if (bad)
			n_fail++;
		else
		begin
			n_pass++;
			$display("ok %s", e.name);
		end
	endtask

	// ==================================================================
	// run control
	// ==================================================================
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles > limit)
		begin
			$display("timeout: the run did not finish within %0d cycles", limit);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial
	begin
		req = 1'b0;
		we = 1'b0;
		adr = '0;
		wdat = '0;
		irq_bus = '0;
		chan_clk = '0;
		chan_gate = '0;
		lfsr = 16'd94;
		n_pass = 0;
		n_fail = 0;
		build_table();
		limit = tbl.size() * 64 + 200;
		wait (rst_n === 1'b1);
		@(negedge clk);
		// output pins straight out of reset
		if ({irq, ack, err, tmr_out, cause} !== 15'd0)
		begin
			$display("error reset_pins expected %h actual %h", 15'd0,
				{irq, ack, err, tmr_out, cause});
			n_fail++;
		end
		else
		begin
			n_pass++;
			$display("ok reset_pins");
		end
		foreach (tbl[i])
			run_entry(tbl[i]);
		$display("tests %0d passed %0d failed %0d", n_pass + n_fail, n_pass, n_fail);
		if (n_fail == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== mpu_periph.f ====
src/bus_pkg.sv
src/irq_pkg.sv
src/interval_timer.sv
src/irq_controller.sv
src/periph_bus_router.sv
src/mpu_periph.sv
bench/tb_clock_gen.sv
bench/tb_mpu_periph.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = tb_mpu_periph
FILELIST = mpu_periph.f
OBJ_DIR = obj_dir
SIM = $(OBJ_DIR)/V$(TOP)
LOG = sim.log
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
